// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/soc_checker.sv ====
`timescale 1ns/1ps

module soc_checker (
    input logic              clk,
    input logic              rst_i,
    input soc_pkg::bus_req_t core_req_i,
    input soc_pkg::bus_req_t dbg_req_i,
    input soc_pkg::bus_rsp_t core_rsp_o,
    input soc_pkg::bus_rsp_t dbg_rsp_o,
    input logic              halt_i,
    input logic              timer_irq_o,
    input soc_pkg::gpio_t    gpio_o,
    input soc_pkg::gpio_t    gpio_en_o,
    input logic [63:0]       mtime_i,
    input logic              tmr_wr_i
);

    int   err_cnt = 0;
    logic core_req_v;
    logic dbg_req_v;
    logic core_rsp_v;
    logic dbg_rsp_v;

    assign core_req_v = core_req_i.valid;
    assign dbg_req_v  = dbg_req_i.valid;
    assign core_rsp_v = core_rsp_o.valid;
    assign dbg_rsp_v  = dbg_rsp_o.valid;

    // ====================
    // Request and response pairing
    // ====================
    // Exactly one response in the two cycles after a strobe
    core_once: assert property (@(posedge clk) disable iff (rst_i)
        $past(core_req_v, 2) |-> (core_rsp_v != $past(core_rsp_v)))
        else begin
            $error("core request not answered exactly once within 2 cycles");
            err_cnt = err_cnt + 1;
        end

    dbg_once: assert property (@(posedge clk) disable iff (rst_i)
        $past(dbg_req_v, 2) |-> (dbg_rsp_v != $past(dbg_rsp_v)))
        else begin
            $error("debug request not answered exactly once within 2 cycles");
            err_cnt = err_cnt + 1;
        end

    core_no_orphan: assert property (@(posedge clk) disable iff (rst_i)
        core_rsp_v |-> ($past(core_req_v) || $past(core_req_v, 2)))
        else begin
            $error("core response without a prior request");
            err_cnt = err_cnt + 1;
        end

    dbg_no_orphan: assert property (@(posedge clk) disable iff (rst_i)
        dbg_rsp_v |-> ($past(dbg_req_v) || $past(dbg_req_v, 2)))
        else begin
            $error("debug response without a prior request");
            err_cnt = err_cnt + 1;
        end

    // Simultaneous strobes answered in separate cycles, DBG first
    split_grant: assert property (@(posedge clk) disable iff (rst_i)
        $past(core_req_v && dbg_req_v, 2) |-> ($past(dbg_rsp_v) && !$past(core_rsp_v)
                                               && core_rsp_v && !dbg_rsp_v))
        else begin
            $error("simultaneous requests not answered one owner per cycle");
            err_cnt = err_cnt + 1;
        end

    // ====================
    // Reset state and timer freeze
    // ====================
    idle_after_reset: assert property (@(posedge clk)
        $past(rst_i) |-> (!core_rsp_v && !dbg_rsp_v && !timer_irq_o
                          && gpio_o == '0 && gpio_en_o == '0))
        else begin
            $error("outputs not inactive after reset");
            err_cnt = err_cnt + 1;
        end

    halt_freeze: assert property (@(posedge clk) disable iff (rst_i)
        (halt_i && !tmr_wr_i) |=> $stable(mtime_i))
        else begin
            $error("mtime changed while halted");
            err_cnt = err_cnt + 1;
        end

endmodule

bind soc_top soc_checker u_chk (
    .*,
    .mtime_i  (u_tmr.mtime_q),
    .tmr_wr_i (u_tmr.wr_en)
);

// ==== dv/soc_tb.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_tb;

    localparam int N_FILL = 8;
    localparam int N_RAM  = 24;
    localparam int N_ARB  = 4;
    // Timer, GPIO and unmapped sections add 13 accesses
    localparam int N_TXN  = 2 * N_FILL + N_RAM + N_ARB + 13;
    localparam int WATCHDOG_CYCLES = N_TXN * 4 + 200;

    logic              clk = 1'b0;
    logic              rst;
    logic              halt;
    logic              timer_irq;
    soc_pkg::bus_req_t core_req;
    soc_pkg::bus_req_t dbg_req;
    soc_pkg::bus_rsp_t core_rsp;
    soc_pkg::bus_rsp_t dbg_rsp;
    soc_pkg::gpio_t    gpio_in;
    soc_pkg::gpio_t    gpio_out;
    soc_pkg::gpio_t    gpio_en;

    logic [31:0]       lfsr = 32'hf6fd_4d53;
    soc_pkg::data_t    ram_model [N_FILL];
    soc_pkg::gpio_t    out_model;
    soc_pkg::gpio_t    oe_model;

    soc_top u_dut (
        .clk         (clk),
        .rst_i       (rst),
        .core_req_i  (core_req),
        .dbg_req_i   (dbg_req),
        .core_rsp_o  (core_rsp),
        .dbg_rsp_o   (dbg_rsp),
        .halt_i      (halt),
        .timer_irq_o (timer_irq),
        .gpio_i      (gpio_in),
        .gpio_o      (gpio_out),
        .gpio_en_o   (gpio_en)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic soc_pkg::addr_t ram_addr(input logic [2:0] idx);
        return `SOC_RAM_BASE | {27'd0, idx, 2'b00};
    endfunction

    function automatic soc_pkg::addr_t reg_addr(input soc_pkg::addr_t base, input logic [3:0] off);
        return base | {28'd0, off};
    endfunction

    function automatic soc_pkg::bus_req_t mk_req(
        input logic           wr,
        input soc_pkg::addr_t addr,
        input soc_pkg::data_t data,
        input soc_pkg::strb_t strb
    );
        soc_pkg::bus_req_t r;
        r.valid = 1'b1;
        r.write = wr;
        r.addr  = addr;
        r.data  = data;
        r.strb  = strb;
        return r;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_eq(input string name, input soc_pkg::data_t got, input soc_pkg::data_t exp);
        assert (got == exp) else begin
            stop_on_error($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // Strobe one or both masters, then collect the responses and their latency
    task automatic run_txn(
        input  soc_pkg::bus_req_t c_req,
        input  soc_pkg::bus_req_t d_req,
        output soc_pkg::data_t    c_data,
        output soc_pkg::data_t    d_data,
        output int                c_lat,
        output int                d_lat
    );
        logic c_done;
        logic d_done;
        int   cyc;
        c_done = !c_req.valid;
        d_done = !d_req.valid;
        c_data = '0;
        d_data = '0;
        c_lat  = 0;
        d_lat  = 0;
        cyc    = 0;
        @(posedge clk);
        core_req <= c_req;
        dbg_req  <= d_req;
        @(posedge clk);
        core_req <= '0;
        dbg_req  <= '0;
        while (!(c_done && d_done) && cyc < 4) begin
            @(negedge clk);
            cyc++;
            if (!c_done && core_rsp.valid) begin
                c_done = 1'b1;
                c_lat  = cyc;
                c_data = core_rsp.data;
            end
            if (!d_done && dbg_rsp.valid) begin
                d_done = 1'b1;
                d_lat  = cyc;
                d_data = dbg_rsp.data;
            end
        end
        assert (c_done && d_done) else begin
            stop_on_error("no response within 4 cycles of a request");
        end
    endtask

    task automatic access(
        input  soc_pkg::master_e mst,
        input  logic             wr,
        input  soc_pkg::addr_t   addr,
        input  soc_pkg::data_t   wdata,
        input  soc_pkg::strb_t   strb,
        output soc_pkg::data_t   rdata
    );
        soc_pkg::data_t c_d;
        soc_pkg::data_t d_d;
        int             c_lat;
        int             d_lat;
        if (mst == soc_pkg::DBG) begin
            run_txn('0, mk_req(wr, addr, wdata, strb), c_d, d_d, c_lat, d_lat);
            rdata = d_d;
            c_lat = d_lat;
        end else begin
            run_txn(mk_req(wr, addr, wdata, strb), '0, c_d, d_d, c_lat, d_lat);
            rdata = c_d;
        end
        check_eq("single access latency", soc_pkg::data_t'(c_lat), 32'd1);
    endtask

    // ====================
    // Watchdog and checker monitor
    // ====================
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("timeout: run did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    always @(negedge clk) begin
        if (u_dut.u_chk.err_cnt != 0) begin
            stop_on_error("protocol checker reported an assertion failure");
        end
    end

    initial begin
        soc_pkg::data_t rdata;
        soc_pkg::data_t wdata;
        soc_pkg::data_t mask;
        soc_pkg::data_t cmp;
        soc_pkg::data_t t_a;
        soc_pkg::data_t t_b;
        soc_pkg::data_t c_d;
        soc_pkg::data_t d_d;
        soc_pkg::strb_t strb;
        soc_pkg::gpio_t pin_val;
        logic [2:0]     idx;
        logic [2:0]     c_idx;
        logic [2:0]     d_idx;
        int             c_lat;
        int             d_lat;
        int             cyc;

        core_req <= '0;
        dbg_req  <= '0;
        halt     <= 1'b0;
        gpio_in  <= '0;
        rst      <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!core_rsp.valid && !dbg_rsp.valid && !timer_irq && gpio_out == '0
                && gpio_en == '0) else begin
            stop_on_error("outputs not inactive after reset");
        end

        // RAM fill with full words so every model word is known
        for (int i = 0; i < N_FILL; i++) begin
            wdata = rand_bits(32);
            access(soc_pkg::master_e'(i[0]), 1'b1, ram_addr(i[2:0]), wdata, 4'hf, rdata);
            ram_model[i[2:0]] = wdata;
        end
        // Byte-strobed writes return the old word
        for (int i = 0; i < N_RAM; i++) begin
            idx   = 3'(rand_bits(3));
            wdata = rand_bits(32);
            strb  = soc_pkg::strb_t'(rand_bits(4));
            access(soc_pkg::master_e'(i[0]), 1'b1, ram_addr(idx), wdata, strb, rdata);
            check_eq("ram old word", rdata, ram_model[idx]);
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            ram_model[idx] = (ram_model[idx] & ~mask) | (wdata & mask);
        end
        for (int i = 0; i < N_FILL; i++) begin
            access(soc_pkg::master_e'(i[0]), 1'b0, ram_addr(i[2:0]), 32'd0, 4'h0, rdata);
            check_eq("ram read", rdata, ram_model[i[2:0]]);
        end

        // ====================
        // Arbitration
        // ====================
        for (int i = 0; i < N_ARB; i++) begin
            c_idx = 3'(rand_bits(3));
            // DBG reads another word so swapped data shows up
            d_idx = c_idx + 3'd1 + 3'(rand_bits(2));
            run_txn(mk_req(1'b0, ram_addr(c_idx), '0, '0), mk_req(1'b0, ram_addr(d_idx), '0, '0),
                    c_d, d_d, c_lat, d_lat);
            check_eq("dbg latency", soc_pkg::data_t'(d_lat), 32'd1);
            check_eq("core latency", soc_pkg::data_t'(c_lat), 32'd2);
            check_eq("core_rsp data", c_d, ram_model[c_idx]);
            check_eq("dbg_rsp data", d_d, ram_model[d_idx]);
        end

        // Timer compare interrupt
        access(soc_pkg::DBG, 1'b0, reg_addr(`SOC_TIMER_BASE, `SOC_TMR_MTIME_LO), 32'd0, 4'h0, rdata);
        cmp = rdata + 32'd20;
        access(soc_pkg::CORE, 1'b1, reg_addr(`SOC_TIMER_BASE, `SOC_TMR_CMP_HI), 32'd0, 4'hf, rdata);
        access(soc_pkg::CORE, 1'b1, reg_addr(`SOC_TIMER_BASE, `SOC_TMR_CMP_LO), cmp, 4'hf, rdata);
        cyc = 0;
        while (!timer_irq && cyc < 25) begin
            @(negedge clk);
            cyc++;
        end
        assert (timer_irq) else begin
            stop_on_error("timer_irq_o did not rise within 25 cycles of the compare write");
        end

        // Halt freezes mtime
        @(posedge clk);
        halt <= 1'b1;
        access(soc_pkg::DBG, 1'b0, reg_addr(`SOC_TIMER_BASE, `SOC_TMR_MTIME_LO), 32'd0, 4'h0, t_a);
        access(soc_pkg::CORE, 1'b0, reg_addr(`SOC_TIMER_BASE, `SOC_TMR_MTIME_LO), 32'd0, 4'h0, t_b);
        check_eq("mtime while halted", t_b, t_a);
        @(posedge clk);
        halt <= 1'b0;

        // ====================
        // GPIO
        // ====================
        out_model = soc_pkg::gpio_t'(rand_bits(24));
        oe_model  = soc_pkg::gpio_t'(rand_bits(24));
        access(soc_pkg::CORE, 1'b1, reg_addr(`SOC_GPIO_BASE, `SOC_GPIO_OUT),
               soc_pkg::data_t'(out_model), 4'hf, rdata);
        access(soc_pkg::DBG, 1'b1, reg_addr(`SOC_GPIO_BASE, `SOC_GPIO_OE),
               soc_pkg::data_t'(oe_model), 4'hf, rdata);
        check_eq("gpio_o", soc_pkg::data_t'(gpio_out), soc_pkg::data_t'(out_model));
        check_eq("gpio_en_o", soc_pkg::data_t'(gpio_en), soc_pkg::data_t'(oe_model));
        access(soc_pkg::DBG, 1'b0, reg_addr(`SOC_GPIO_BASE, `SOC_GPIO_OUT), 32'd0, 4'h0, rdata);
        check_eq("gpio out readback", rdata, soc_pkg::data_t'(out_model));
        @(posedge clk);
        pin_val = soc_pkg::gpio_t'(rand_bits(24));
        gpio_in <= pin_val;
        repeat (3) @(posedge clk);
        access(soc_pkg::CORE, 1'b0, reg_addr(`SOC_GPIO_BASE, `SOC_GPIO_IN), 32'd0, 4'h0, rdata);
        check_eq("gpio input register", rdata, soc_pkg::data_t'(pin_val));

        // Unmapped region reads zero and ignores writes
        access(soc_pkg::CORE, 1'b0, 32'h4000_0000, 32'd0, 4'h0, rdata);
        check_eq("unmapped read", rdata, 32'd0);
        access(soc_pkg::DBG, 1'b1, 32'h4000_0000, 32'hffff_ffff, 4'hf, rdata);
        access(soc_pkg::CORE, 1'b0, ram_addr(3'd0), 32'd0, 4'h0, rdata);
        check_eq("ram word 0 after unmapped write", rdata, ram_model[0]);
        access(soc_pkg::DBG, 1'b0, reg_addr(`SOC_GPIO_BASE, `SOC_GPIO_OUT), 32'd0, 4'h0, rdata);
        check_eq("gpio out after unmapped write", rdata, soc_pkg::data_t'(out_model));

        repeat (4) @(negedge clk);
        if (u_dut.u_chk.err_cnt == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_error("protocol checker reported an assertion failure");
        end
    end

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic              clk,
    input  logic              rst_i,
    input  soc_pkg::bus_req_t core_req_i,
    input  soc_pkg::bus_req_t dbg_req_i,
    output soc_pkg::bus_req_t grant_req_o,
    output soc_pkg::master_e  grant_mst_o
);

    // One-entry slot for the request that lost
    logic              hold_vld_q;
    soc_pkg::bus_req_t hold_req_q;
    soc_pkg::master_e  hold_mst_q;

    logic              load_en;
    soc_pkg::bus_req_t load_req;
    soc_pkg::master_e  load_mst;

    // ====================
    // Fixed priority: slot, then DBG, then CORE
    // ====================
    always_comb begin
        grant_req_o = '0;
        grant_mst_o = soc_pkg::CORE;
        load_en     = 1'b0;
        load_req    = core_req_i;
        load_mst    = soc_pkg::CORE;

        if (hold_vld_q) begin
            grant_req_o = hold_req_q;
            grant_mst_o = hold_mst_q;
            // A fresh strobe here waits in the slot behind the held one
            if (dbg_req_i.valid) begin
                load_en  = 1'b1;
                load_req = dbg_req_i;
                load_mst = soc_pkg::DBG;
            end else if (core_req_i.valid) begin
                load_en  = 1'b1;
            end
        end else if (dbg_req_i.valid) begin
            grant_req_o = dbg_req_i;
            grant_mst_o = soc_pkg::DBG;
            load_en     = core_req_i.valid;
        end else if (core_req_i.valid) begin
            grant_req_o = core_req_i;
            grant_mst_o = soc_pkg::CORE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_vld_q <= 1'b0;
        end else begin
            hold_vld_q <= load_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            hold_req_q <= load_req;
            hold_mst_q <= load_mst;
        end
    end

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module bus_decoder (
    input  logic              clk,
    input  logic              rst_i,
    input  soc_pkg::bus_req_t grant_req_i,
    input  soc_pkg::master_e  grant_mst_i,
    output logic              ram_sel_o,
    output logic              tmr_sel_o,
    output logic              gpio_sel_o,
    input  soc_pkg::data_t    ram_rdata_i,
    input  soc_pkg::data_t    tmr_rdata_i,
    input  soc_pkg::data_t    gpio_rdata_i,
    output soc_pkg::bus_rsp_t core_rsp_o,
    output soc_pkg::bus_rsp_t dbg_rsp_o
);

    localparam soc_pkg::addr_t RAM_BASE  = `SOC_RAM_BASE;
    localparam soc_pkg::addr_t TMR_BASE  = `SOC_TIMER_BASE;
    localparam soc_pkg::addr_t GPIO_BASE = `SOC_GPIO_BASE;

    soc_pkg::target_e tgt;
    soc_pkg::target_e tgt_q;
    soc_pkg::master_e mst_q;
    logic             rsp_vld_q;
    soc_pkg::data_t   rsp_data;

    // Region match on the upper address bits
    always_comb begin
        if (grant_req_i.addr[31:`SOC_REGION_BITS] == RAM_BASE[31:`SOC_REGION_BITS]) begin
            tgt = soc_pkg::RAM;
        end else if (grant_req_i.addr[31:`SOC_REGION_BITS] == TMR_BASE[31:`SOC_REGION_BITS]) begin
            tgt = soc_pkg::TIMER;
        end else if (grant_req_i.addr[31:`SOC_REGION_BITS] == GPIO_BASE[31:`SOC_REGION_BITS]) begin
            tgt = soc_pkg::GPIO;
        end else begin
            tgt = soc_pkg::NONE;
        end
    end

    assign ram_sel_o  = grant_req_i.valid && (tgt == soc_pkg::RAM);
    assign tmr_sel_o  = grant_req_i.valid && (tgt == soc_pkg::TIMER);
    assign gpio_sel_o = grant_req_i.valid && (tgt == soc_pkg::GPIO);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_vld_q <= 1'b0;
        end else begin
            rsp_vld_q <= grant_req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        tgt_q <= tgt;
        mst_q <= grant_mst_i;
    end

    // ====================
    // Response routing
    // ====================
    always_comb begin
        case (tgt_q)
            soc_pkg::RAM:   rsp_data = ram_rdata_i;
            soc_pkg::TIMER: rsp_data = tmr_rdata_i;
            soc_pkg::GPIO:  rsp_data = gpio_rdata_i;
            default:        rsp_data = '0;
        endcase
    end

    assign core_rsp_o.valid = rsp_vld_q && (mst_q == soc_pkg::CORE);
    assign core_rsp_o.data  = rsp_data;
    assign dbg_rsp_o.valid  = rsp_vld_q && (mst_q == soc_pkg::DBG);
    assign dbg_rsp_o.data   = rsp_data;

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module data_ram (
    input  logic              clk,
    input  logic              sel_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::data_t    rdata_o
);

    localparam int unsigned IDX_W = $clog2(`SOC_RAM_WORDS);

    soc_pkg::data_t   mem [`SOC_RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index, wraps at the RAM depth
    assign idx = req_i.addr[IDX_W+1:2];

    // Read returns the old word, also on a write
    always_ff @(posedge clk) begin
        if (sel_i) begin
            rdata_o <= mem[idx];
        end
    end

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (sel_i && req_i.write) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.strb[i]) begin
                    mem[idx][8*i +: 8] <= req_i.data[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/gpio_regs.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module gpio_regs (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              sel_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::data_t    rdata_o,
    input  soc_pkg::gpio_t    gpio_i,
    output soc_pkg::gpio_t    gpio_o,
    output soc_pkg::gpio_t    gpio_en_o
);

    soc_pkg::gpio_t sync_q1;
    soc_pkg::gpio_t sync_q2;
    logic           wr_en;

    assign wr_en = sel_i && req_i.write;

    // Two-flop synchronizer on the pins
    always_ff @(posedge clk) begin
        sync_q1 <= gpio_i;
        sync_q2 <= sync_q1;
    end

    // ====================
    // Output and enable
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            gpio_o    <= '0;
            gpio_en_o <= '0;
        end else if (wr_en) begin
            if (req_i.addr[3:0] == `SOC_GPIO_OUT) begin
                gpio_o <= req_i.data[`SOC_GPIO_PINS-1:0];
            end
            if (req_i.addr[3:0] == `SOC_GPIO_OE) begin
                gpio_en_o <= req_i.data[`SOC_GPIO_PINS-1:0];
            end
        end
    end

    // Read back, zero-extended to a bus word
    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (req_i.addr[3:0])
                `SOC_GPIO_OUT: rdata_o <= soc_pkg::data_t'(gpio_o);
                `SOC_GPIO_OE:  rdata_o <= soc_pkg::data_t'(gpio_en_o);
                `SOC_GPIO_IN:  rdata_o <= soc_pkg::data_t'(sync_q2);
                default:       rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== logic/mtimer.sv ====
`timescale 1ns/1ps
`include "soc_params.svh"

module mtimer (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              sel_i,
    input  soc_pkg::bus_req_t req_i,
    input  logic              halt_i,
    output soc_pkg::data_t    rdata_o,
    output logic              irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        wr_en;

    assign wr_en = sel_i && req_i.write;

    // ====================
    // Counter and compare
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_o      <= 1'b0;
        end else begin
            // Frozen while the debugger halts the core
            if (!halt_i) begin
                mtime_q <= mtime_q + 64'd1;
            end
            // A bus write overrides the count
            if (wr_en) begin
                case (req_i.addr[3:0])
                    `SOC_TMR_MTIME_LO: mtime_q[31:0]     <= req_i.data;
                    `SOC_TMR_MTIME_HI: mtime_q[63:32]    <= req_i.data;
                    `SOC_TMR_CMP_LO:   mtimecmp_q[31:0]  <= req_i.data;
                    `SOC_TMR_CMP_HI:   mtimecmp_q[63:32] <= req_i.data;
                    default: ;
                endcase
            end
            irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            case (req_i.addr[3:0])
                `SOC_TMR_MTIME_LO: rdata_o <= mtime_q[31:0];
                `SOC_TMR_MTIME_HI: rdata_o <= mtime_q[63:32];
                `SOC_TMR_CMP_LO:   rdata_o <= mtimecmp_q[31:0];
                `SOC_TMR_CMP_HI:   rdata_o <= mtimecmp_q[63:32];
                default:           rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== logic/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Target base addresses
`define SOC_RAM_BASE      32'h0000_0000
`define SOC_TIMER_BASE    32'h0200_0000
`define SOC_GPIO_BASE     32'h2000_0000

// Low address bits inside one target region
`define SOC_REGION_BITS   16

`define SOC_RAM_WORDS     256
`define SOC_GPIO_PINS     24

// Timer register offsets
`define SOC_TMR_MTIME_LO  4'h0
`define SOC_TMR_MTIME_HI  4'h4
`define SOC_TMR_CMP_LO    4'h8
`define SOC_TMR_CMP_HI    4'hC

// GPIO register offsets
`define SOC_GPIO_OUT      4'h0
`define SOC_GPIO_OE       4'h4
`define SOC_GPIO_IN       4'h8

`endif

// ==== logic/soc_pkg.sv ====
`include "soc_params.svh"

package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef logic [`SOC_GPIO_PINS-1:0] gpio_t;

    // One-cycle request strobe from a master
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t data;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } bus_rsp_t;

    typedef enum logic {
        CORE,
        DBG
    } master_e;

    typedef enum logic [1:0] {
        RAM,
        TIMER,
        GPIO,
        NONE
    } target_e;

endpackage

// ==== logic/soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
    input  logic              clk,
    input  logic              rst_i,
    input  soc_pkg::bus_req_t core_req_i,
    input  soc_pkg::bus_req_t dbg_req_i,
    output soc_pkg::bus_rsp_t core_rsp_o,
    output soc_pkg::bus_rsp_t dbg_rsp_o,
    input  logic              halt_i,
    output logic              timer_irq_o,
    input  soc_pkg::gpio_t    gpio_i,
    output soc_pkg::gpio_t    gpio_o,
    output soc_pkg::gpio_t    gpio_en_o
);

    soc_pkg::bus_req_t grant_req;
    soc_pkg::master_e  grant_mst;

    logic           ram_sel;
    logic           tmr_sel;
    logic           gpio_sel;
    soc_pkg::data_t ram_rdata;
    soc_pkg::data_t tmr_rdata;
    soc_pkg::data_t gpio_rdata;

    // ====================
    // Shared bus
    // ====================
    bus_arbiter u_arb (
        .clk         (clk),
        .rst_i       (rst_i),
        .core_req_i  (core_req_i),
        .dbg_req_i   (dbg_req_i),
        .grant_req_o (grant_req),
        .grant_mst_o (grant_mst)
    );

    bus_decoder u_dec (
        .clk          (clk),
        .rst_i        (rst_i),
        .grant_req_i  (grant_req),
        .grant_mst_i  (grant_mst),
        .ram_sel_o    (ram_sel),
        .tmr_sel_o    (tmr_sel),
        .gpio_sel_o   (gpio_sel),
        .ram_rdata_i  (ram_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .gpio_rdata_i (gpio_rdata),
        .core_rsp_o   (core_rsp_o),
        .dbg_rsp_o    (dbg_rsp_o)
    );

    // ====================
    // Targets
    // ====================
    data_ram u_ram (
        .clk     (clk),
        .sel_i   (ram_sel),
        .req_i   (grant_req),
        .rdata_o (ram_rdata)
    );

    mtimer u_tmr (
        .clk     (clk),
        .rst_i   (rst_i),
        .sel_i   (tmr_sel),
        .req_i   (grant_req),
        .halt_i  (halt_i),
        .rdata_o (tmr_rdata),
        .irq_o   (timer_irq_o)
    );

    gpio_regs u_gpio (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (gpio_sel),
        .req_i     (grant_req),
        .rdata_o   (gpio_rdata),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_en_o (gpio_en_o)
    );

endmodule

// ==== sources.f ====
+incdir+logic
logic/soc_pkg.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/data_ram.sv
logic/mtimer.sv
logic/gpio_regs.sv
logic/soc_top.sv
dv/soc_checker.sv
dv/soc_tb.sv
